// File: bench/exu_checker.sv
// Execute unit assertion checker
// Bound to the top level. Covers zero outputs during reset,
// quiet LSU operands without qualification and masked history
// in the branch report.

`timescale 1ns/1ps

`include "exu_params.svh"

module exu_checker (
   input  logic                       clk,
   input  logic                       i_rst_n,
   input  logic                       i_qual_lsu,
   input  logic [`EXU_XLEN-1:0]       i_lsu_rs1,
   input  logic [`EXU_XLEN-1:0]       i_lsu_rs2,
   input  exu_pkg::br_update_t        i_br_update,
   input  exu_pkg::mispredict_t       i_mp,
   input  logic [`EXU_XLEN-1:1]       i_npc_r
);

   int fail_count = 0;                 // Failed assertion count

   // Registered outputs read zero while reset is held
   reset_zero_a : assert property (@(posedge clk)
      !i_rst_n |-> (i_br_update == '0 && i_mp == '0 && i_npc_r == '0))
      else begin
         $error("Outputs not zero during reset");
         fail_count++;
      end

   lsu_gated_a : assert property (@(posedge clk) disable iff (!i_rst_n)
      !i_qual_lsu |-> (i_lsu_rs1 == '0 && i_lsu_rs2 == '0))
      else begin
         $error("LSU operands active without qualification");
         fail_count++;
      end

   // History only reported with a valid branch
   hist_masked_a : assert property (@(posedge clk) disable iff (!i_rst_n)
      !i_br_update.valid |-> (i_br_update.hist == 2'b00))
      else begin
         $error("Branch report history set without valid");
         fail_count++;
      end

endmodule

// File: bench/exu_tb.sv
// Execute unit forwarding slice testbench
// Directed tests for operand selection, LSU gating, the branch
// prediction pipe, mispredict report, global history and flush.

`timescale 1ns/1ps

`include "exu_params.svh"

module exu_tb;
   import exu_pkg::*;

   localparam int TIMEOUT_CYC = 20;

   logic                       clk;
   logic                       i_rst_n;
   stage_en_t                  i_en;
   bypass_t                    i_byp;
   logic [`EXU_BYP_SRCS-1:0]   i_rs1_byp_en;
   logic [`EXU_BYP_SRCS-1:0]   i_rs2_byp_en;
   logic                       i_rs1_en;
   logic                       i_rs2_en;
   logic                       i_select_pc;
   logic                       i_dbg_rs1;
   logic                       i_qual_lsu;
   logic                       i_extint_stall;
   logic [`EXU_XLEN-1:0]       i_gpr_rs1;
   logic [`EXU_XLEN-1:0]       i_gpr_rs2;
   logic [`EXU_XLEN-1:0]       i_immed;
   logic [`EXU_XLEN-1:0]       i_dbg_wrdata;
   logic [`EXU_XLEN-1:1]       i_pc_d;
   logic [`EXU_XLEN-1:2]       i_meihap;
   predict_pkt_t               i_pp_d;
   predpipe_t                  i_predpipe_d;
   resolve_t                   i_res_d;
   logic [`EXU_XLEN-1:1]       i_npc_x;
   logic [`EXU_XLEN-1:1]       i_flush_path_lower;
   logic                       i_branch_d;
   logic                       i_alu_decode_d;
   logic                       i_flush_lower;
   logic [`EXU_XLEN-1:0]       o_rs1;
   logic [`EXU_XLEN-1:0]       o_rs2;
   logic [`EXU_XLEN-1:0]       o_lsu_rs1;
   logic [`EXU_XLEN-1:0]       o_lsu_rs2;
   br_update_t                 o_br_update;
   mispredict_t                o_mp;
   logic                       o_flush_final;
   logic [`EXU_XLEN-1:1]       o_flush_path_final;
   logic [`EXU_XLEN-1:1]       o_npc_r;
   int                         err_count;

   exu_top u_dut (.*);

   bind exu_top exu_checker u_checker (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_qual_lsu  (i_qual_lsu),
      .i_lsu_rs1   (o_lsu_rs1),
      .i_lsu_rs2   (o_lsu_rs2),
      .i_br_update (o_br_update),
      .i_mp        (o_mp),
      .i_npc_r     (o_npc_r)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic fail_run(input string why);
      err_count++;
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1, "Run stopped at first error");
   endtask

   task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("Mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
         fail_run("Value check failed");
      end
   endtask

   always @(posedge clk) begin
      if (u_dut.u_checker.fail_count != 0)
         fail_run("An assertion in the bound checker failed");
   end

   task automatic next_slot();
      @(posedge clk);
      #1;                                            // Drive point after the edge
   endtask

   task automatic settle();
      #1;
   endtask

   // Polls either the branch report (0) or the mispredict report (1)
   task automatic wait_valid(input int which, input string what);
      int   cycles;
      logic seen;
      cycles = 0;
      seen   = (which == 0) ? o_br_update.valid : o_mp.pkt.valid;
      while (!seen && cycles < TIMEOUT_CYC) begin
         next_slot();
         settle();
         cycles++;
         seen = (which == 0) ? o_br_update.valid : o_mp.pkt.valid;
      end
      if (!seen)
         fail_run({"Timeout waiting for ", what});
   endtask

   function automatic logic [31:0] byp_or(input bypass_t b, input logic [3:0] en);
      logic [31:0] acc;
      acc = '0;
      if (en[0]) acc = acc | b.result_r;
      if (en[1]) acc = acc | b.load_m;
      if (en[2]) acc = acc | b.result_x;
      if (en[3]) acc = acc | b.load_nb;
      return acc;
   endfunction

   task automatic init_inputs();
      i_rst_n            = 1'b1;
      i_en               = '0;
      i_byp              = '0;
      i_rs1_byp_en       = '0;
      i_rs2_byp_en       = '0;
      i_rs1_en           = 1'b0;
      i_rs2_en           = 1'b0;
      i_select_pc        = 1'b0;
      i_dbg_rs1          = 1'b0;
      i_qual_lsu         = 1'b0;
      i_extint_stall     = 1'b0;
      i_gpr_rs1          = '0;
      i_gpr_rs2          = '0;
      i_immed            = '0;
      i_dbg_wrdata       = '0;
      i_pc_d             = '0;
      i_meihap           = '0;
      i_pp_d             = '0;
      i_predpipe_d       = '0;
      i_res_d            = '0;
      i_npc_x            = '0;
      i_flush_path_lower = '0;
      i_branch_d         = 1'b0;
      i_alu_decode_d     = 1'b0;
      i_flush_lower      = 1'b0;
   endtask

   task automatic do_reset();
      next_slot();
      i_rst_n = 1'b0;
      repeat (5) @(posedge clk);
      #1 i_rst_n = 1'b1;
   endtask

   task automatic operand_mux();
      logic [3:0]  en;
      logic [3:0]  en2;
      logic [31:0] r;
      logic [31:0] exp1;
      logic [31:0] exp2;
      next_slot();
      i_byp.result_r = $urandom;
      i_byp.load_m   = $urandom;
      i_byp.result_x = $urandom;
      i_byp.load_nb  = $urandom;
      i_gpr_rs1      = $urandom;
      i_gpr_rs2      = $urandom;
      i_immed        = $urandom;
      i_dbg_wrdata   = $urandom;
      r              = $urandom;
      i_pc_d         = r[31:1];
      i_rs1_en       = 1'b1;
      i_rs2_en       = 1'b1;
      for (int k = 1; k < 16; k++) begin
         en  = k[3:0];
         en2 = {en[2:0], en[3]};                     // Different sources on rs2
         if ($countones(en) <= 2) begin
            next_slot();
            i_rs1_byp_en = en;
            i_rs2_byp_en = en2;
            i_select_pc  = 1'b1;                     // Bypass still wins
            i_dbg_rs1    = 1'b1;
            settle();
            compare("o_rs1", o_rs1, byp_or(i_byp, en));
            compare("o_rs2", o_rs2, byp_or(i_byp, en2));
         end
      end
      for (int k = 0; k < 8; k++) begin
         next_slot();
         i_rs1_byp_en = '0;
         i_rs2_byp_en = '0;
         i_select_pc  = k[2];
         i_dbg_rs1    = k[1];
         i_rs1_en     = k[0];
         i_rs2_en     = k[0];
         if (k[2])
            exp1 = {i_pc_d, 1'b0};
         else if (k[1])
            exp1 = i_dbg_wrdata;
         else
            exp1 = k[0] ? i_gpr_rs1 : 32'h0;
         exp2 = (k[0] ? i_gpr_rs2 : 32'h0) | i_immed;
         settle();
         compare("o_rs1", o_rs1, exp1);
         compare("o_rs2", o_rs2, exp2);
      end
      next_slot();
      i_select_pc = 1'b0;
      i_dbg_rs1   = 1'b0;
   endtask

   task automatic lsu_gating();
      logic [31:0] r;
      next_slot();
      i_rs1_en       = 1'b1;
      i_rs2_en       = 1'b1;
      i_qual_lsu     = 1'b0;
      i_extint_stall = 1'b1;
      settle();
      compare("o_lsu_rs1", o_lsu_rs1, 32'h0);
      compare("o_lsu_rs2", o_lsu_rs2, 32'h0);
      next_slot();
      i_qual_lsu     = 1'b1;
      i_extint_stall = 1'b0;
      settle();
      compare("o_lsu_rs1", o_lsu_rs1, i_gpr_rs1);
      compare("o_lsu_rs2", o_lsu_rs2, i_gpr_rs2);
      next_slot();
      i_rs1_byp_en = 4'b0100;
      i_rs2_byp_en = 4'b0010;
      settle();
      compare("o_lsu_rs1", o_lsu_rs1, i_byp.result_x);
      compare("o_lsu_rs2", o_lsu_rs2, i_byp.load_m);
      next_slot();
      r              = $urandom;
      i_meihap       = r[31:2];
      i_extint_stall = 1'b1;
      settle();
      compare("o_lsu_rs1", o_lsu_rs1, {r[31:2], 2'b00});
      compare("o_lsu_rs2", o_lsu_rs2, 32'h0);
      next_slot();
      i_qual_lsu     = 1'b0;
      i_extint_stall = 1'b0;
      i_rs1_byp_en   = '0;
      i_rs2_byp_en   = '0;
   endtask

   task automatic pipeline_delivery();
      predict_pkt_t pp;
      predpipe_t    pq;
      predpipe_t    pq_old;
      br_update_t   exp;
      logic [31:0]  r;
      logic         pc1;
      pq_old = '0;
      for (int pass = 0; pass < 2; pass++) begin
         r        = $urandom;
         pp       = r[24:0];
         pp.valid = 1'b1;
         r        = $urandom;
         pq       = r[20:0];
         r        = $urandom;
         pc1      = r[1];
         next_slot();
         i_pp_d         = pp;
         i_pc_d         = r[31:1];
         i_predpipe_d   = pq;
         i_branch_d     = (pass == 0);               // Second pass is not a branch
         i_alu_decode_d = 1'b1;
         i_en.data_x    = 1'b1;
         i_en.ctl_x     = 1'b1;
         next_slot();
         i_pp_d       = '0;
         i_predpipe_d = '0;
         i_branch_d   = 1'b0;
         i_en.data_x  = 1'b0;
         i_en.ctl_x   = 1'b0;
         i_en.data_r  = 1'b1;
         i_en.ctl_r   = 1'b1;
         next_slot();
         i_en = '0;
         settle();
         wait_valid(0, "branch update");
         if (pass == 0)
            pq_old = pq;
         exp.valid       = 1'b1;
         exp.misp        = pp.misp;
         exp.way         = pp.way;
         exp.hist        = pp.hist;
         exp.error       = pp.br_error;
         exp.start_error = pp.br_start_error;
         exp.middle      = pp.pc4 ^ pc1;
         exp.index       = pq_old.index;
         exp.fghr        = pq_old.fghr;
         compare("o_br_update", o_br_update, exp);
      end
      i_alu_decode_d = 1'b0;
   endtask

   task automatic mispredict_report();
      predict_pkt_t pp;
      predpipe_t    pq;
      logic [31:0]  r;
      r        = $urandom;
      pp       = r[24:0];
      pp.valid = 1'b1;
      r        = $urandom;
      pq       = r[20:0];
      r        = $urandom;
      next_slot();
      i_pp_d              = pp;
      i_pc_d              = r[31:1];
      i_predpipe_d        = pq;
      i_branch_d          = 1'b1;
      i_res_d.flush_upper = 1'b1;
      i_en.data_x         = 1'b1;
      i_en.ctl_x          = 1'b1;
      next_slot();
      i_en       = '0;
      i_res_d    = '0;
      i_pp_d     = '0;
      i_branch_d = 1'b0;
      settle();
      wait_valid(1, "mispredict report");
      pp.boffset = r[1];                             // Offset comes from the PC
      compare("o_mp.pkt", o_mp.pkt, pp);
      compare("o_mp.index", o_mp.index, pq.index);
      compare("o_mp.btag", o_mp.btag, pq.btag);
      next_slot();
      i_pp_d       = pp;
      i_predpipe_d = pq;
      i_branch_d   = 1'b1;
      i_en.data_x  = 1'b1;
      i_en.ctl_x   = 1'b1;
      next_slot();
      i_en         = '0;
      i_pp_d       = '0;
      i_predpipe_d = '0;
      i_branch_d   = 1'b0;
      settle();
      compare("o_mp.pkt", o_mp.pkt, 25'h0);
      compare("o_mp.index", o_mp.index, 8'h0);
      compare("o_mp.btag", o_mp.btag, 5'h0);
   endtask

   task automatic flush_and_npc();
      logic [31:0] r;
      logic [31:0] n;
      next_slot();
      r                   = $urandom;
      n                   = $urandom;
      i_flush_lower       = 1'b1;
      i_flush_path_lower  = r[31:1];
      i_res_d.flush_upper = 1'b0;
      i_res_d.flush_path  = n[31:1];
      settle();
      compare("o_flush_final", o_flush_final, 1'b1);
      compare("o_flush_path_final", o_flush_path_final, r[31:1]);
      next_slot();
      i_res_d.flush_upper = 1'b1;                   // Lower path still first
      settle();
      compare("o_flush_final", o_flush_final, 1'b1);
      compare("o_flush_path_final", o_flush_path_final, r[31:1]);
      next_slot();
      i_flush_lower = 1'b0;
      settle();
      compare("o_flush_final", o_flush_final, 1'b1);
      compare("o_flush_path_final", o_flush_path_final, n[31:1]);
      next_slot();
      i_res_d.flush_upper = 1'b0;
      settle();
      compare("o_flush_final", o_flush_final, 1'b0);
      compare("o_flush_path_final", o_flush_path_final, n[31:1]);
      for (int ok = 0; ok < 2; ok++) begin
         r = $urandom;
         n = $urandom;
         next_slot();
         i_res_d.flush_path   = r[31:1];
         i_res_d.pred_correct = ok[0];
         i_en.data_x          = 1'b1;
         i_en.ctl_x           = 1'b1;
         next_slot();
         i_res_d    = '0;
         i_en       = '0;
         i_en.data_r = 1'b1;
         i_en.ctl_r  = 1'b1;
         i_npc_x     = n[31:1];
         next_slot();
         i_en    = '0;
         i_npc_x = '0;
         settle();
         compare("o_npc_r", o_npc_r, ok[0] ? n[31:1] : r[31:1]);
      end
   endtask

   task automatic history_tracking();
      logic [7:0] ghr_d_m;
      logic [7:0] ghr_x_m;
      logic       valid_x_m;
      logic       taken_x_m;
      logic [7:0] bits;
      logic [1:0] extra;
      ghr_d_m        = '0;
      ghr_x_m        = '0;
      valid_x_m      = 1'b0;
      taken_x_m      = 1'b0;
      bits           = 8'b1011_0010;
      extra          = 2'b01;
      i_alu_decode_d = 1'b1;
      for (int i = 0; i < 8; i++) begin
         next_slot();
         i_pp_d.valid  = 1'b1;
         i_pp_d.ataken = bits[i];
         i_en.ctl_x    = 1'b1;
         next_slot();
         i_pp_d.valid = 1'b0;
         i_en.ctl_x   = 1'b0;
         if (valid_x_m)
            ghr_x_m = {ghr_x_m[6:0], taken_x_m};    // X lags D by one branch
         valid_x_m = 1'b1;
         taken_x_m = bits[i];
         ghr_d_m   = {ghr_d_m[6:0], bits[i]};
         settle();
         compare("o_mp.eghr", o_mp.eghr, ghr_x_m);
      end
      // Upper flush at X exposes the D history
      next_slot();
      i_res_d.flush_upper = 1'b1;
      i_en.ctl_x          = 1'b1;
      next_slot();
      i_res_d.flush_upper = 1'b0;
      i_en.ctl_x          = 1'b0;
      ghr_x_m             = {ghr_x_m[6:0], taken_x_m};
      valid_x_m           = 1'b0;
      settle();
      compare("o_mp.eghr", o_mp.eghr, ghr_d_m);
      for (int j = 0; j < 2; j++) begin
         next_slot();
         i_pp_d.valid  = 1'b1;
         i_pp_d.ataken = extra[j];
         next_slot();
         i_pp_d.valid = 1'b0;
         ghr_d_m      = {ghr_d_m[6:0], extra[j]};
         settle();
         compare("o_mp.eghr", o_mp.eghr, ghr_d_m);
      end
      next_slot();
      i_flush_lower = 1'b1;
      next_slot();
      i_flush_lower = 1'b0;
      ghr_d_m       = ghr_x_m;                       // D restored from X
      settle();
      compare("o_mp.eghr", o_mp.eghr, ghr_d_m);
      i_alu_decode_d = 1'b0;
      i_pp_d         = '0;
   endtask

   initial begin
      void'($urandom(32'h22cb));
      err_count = 0;
      init_inputs();
      do_reset();
      operand_mux();
      lsu_gating();
      pipeline_delivery();
      mispredict_report();
      flush_and_npc();
      do_reset();
      history_tracking();
      next_slot();
      if (err_count == 0 && u_dut.u_checker.fail_count == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

// File: compile.f
+incdir+include
hdl/exu_pkg.sv
hdl/operand_select.sv
hdl/ghr_tracker.sv
hdl/branch_pipe.sv
hdl/exu_top.sv
bench/exu_checker.sv
bench/exu_tb.sv

// File: hdl/branch_pipe.sv
// Branch prediction pipe
// Carries the prediction packet, BTB side data and flush path from
// D through X to R under the decoder stage enables. Produces the
// R-stage branch report, the X-stage mispredict report, the final
// flush selection and the R-stage next PC.

`timescale 1ns/1ps

`include "exu_params.svh"

module branch_pipe (
   input  logic                        clk,
   input  logic                        i_rst_n,
   input  exu_pkg::stage_en_t          i_en,
   input  exu_pkg::predict_pkt_t       i_pp_d,
   input  exu_pkg::predpipe_t          i_predpipe_d,
   input  exu_pkg::resolve_t           i_res_d,            // From the branch resolver
   input  logic [`EXU_XLEN-1:1]        i_pc_d,
   input  logic [`EXU_XLEN-1:1]        i_npc_x,            // NPC if prediction was correct
   input  logic [`EXU_XLEN-1:1]        i_flush_path_lower,
   input  logic                        i_branch_d,
   input  logic                        i_alu_decode_d,
   input  logic                        i_flush_lower,
   output exu_pkg::br_update_t         o_br_update,
   output exu_pkg::mispredict_t        o_mp,
   output logic                        o_flush_final,
   output logic [`EXU_XLEN-1:1]        o_flush_path_final,
   output logic [`EXU_XLEN-1:1]        o_npc_r,
   output logic                        o_valid_d,
   output logic                        o_taken_d,
   output logic                        o_flush_upper_x
);
   import exu_pkg::*;

   predict_pkt_t         pp_new_d;
   predict_pkt_t         pp_x;
   predict_pkt_t         pp_r;
   predpipe_t            predpipe_x;
   predpipe_t            predpipe_r;
   logic                 flush_upper_x;
   logic                 pred_correct_x;
   logic                 pred_correct_r;
   logic                 branch_x;
   logic [`EXU_XLEN-1:1] flush_path_x;
   logic [`EXU_XLEN-1:1] flush_path_r;
   logic [`EXU_XLEN-1:1] npc_r_q;

   always_comb begin
      pp_new_d         = i_pp_d;
      pp_new_d.boffset = i_pc_d[1];                 // Offset from start of instruction
   end

   assign o_valid_d = pp_new_d.valid & i_alu_decode_d & ~i_flush_lower;
   assign o_taken_d = pp_new_d.ataken & i_alu_decode_d;

   // D to X data
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pp_x         <= '0;
         flush_path_x <= '0;
         branch_x     <= 1'b0;
         predpipe_x   <= '0;
      end else if (i_en.data_x) begin
         pp_x         <= pp_new_d;
         flush_path_x <= i_res_d.flush_path;
         branch_x     <= i_branch_d;
         if (i_branch_d)
            predpipe_x <= i_predpipe_d;             // Side data for branches only
      end
   end

   // D to X control
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         flush_upper_x  <= 1'b0;
         pred_correct_x <= 1'b0;
      end else if (i_en.ctl_x) begin
         flush_upper_x  <= i_res_d.flush_upper;
         pred_correct_x <= i_res_d.pred_correct;
      end
   end

   // X to R data
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         flush_path_r <= '0;
         npc_r_q      <= '0;
         predpipe_r   <= '0;
      end else if (i_en.data_r) begin
         flush_path_r <= flush_path_x;
         npc_r_q      <= i_npc_x;
         if (branch_x)
            predpipe_r <= predpipe_x;
      end
   end

   // X to R control
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pp_r           <= '0;
         pred_correct_r <= 1'b0;
      end else if (i_en.ctl_r) begin
         pp_r           <= pp_x;
         pred_correct_r <= pred_correct_x;
      end
   end

   always_comb begin
      o_br_update.valid       = pp_r.valid;
      o_br_update.misp        = pp_r.misp;
      o_br_update.way         = pp_r.way;
      o_br_update.hist        = {2{pp_r.valid}} & pp_r.hist;
      o_br_update.error       = pp_r.br_error;
      o_br_update.start_error = pp_r.br_start_error;
      o_br_update.middle      = pp_r.pc4 ^ pp_r.boffset;   // Ends in the middle of a fetch
      o_br_update.index       = predpipe_r.index;
      o_br_update.fghr        = predpipe_r.fghr;
   end

   // Only an upper flush at X reports a mispredict
   always_comb begin
      o_mp = '0;
      if (flush_upper_x) begin
         o_mp.pkt   = pp_x;
         o_mp.index = predpipe_x.index;
         o_mp.btag  = predpipe_x.btag;
      end
   end

   assign o_flush_upper_x    = flush_upper_x;
   assign o_flush_final      = i_flush_lower | i_res_d.flush_upper;
   assign o_flush_path_final = i_flush_lower ? i_flush_path_lower : i_res_d.flush_path;
   assign o_npc_r            = pred_correct_r ? npc_r_q : flush_path_r;

endmodule

// File: hdl/exu_pkg.sv
// Execute unit types
// Packed structs for the branch prediction packet, its side data,
// decoder stage enables, bypass sources and the branch reports

`include "exu_params.svh"

package exu_pkg;

   typedef struct packed {
      logic        valid;
      logic        way;
      logic        misp;           // Mispredicted at fetch
      logic        pcall;
      logic        pja;
      logic        pret;
      logic        ataken;         // Actual direction
      logic        boffset;        // Branch offset within fetch
      logic        pc4;            // 4-byte instruction
      logic [1:0]  hist;
      logic [11:0] toffset;
      logic        br_error;
      logic        br_start_error;
   } predict_pkt_t;

   typedef struct packed {
      logic [`EXU_GHR_SIZE-1:0]                fghr;
      logic [`EXU_BTB_ADDR_HI:`EXU_BTB_ADDR_LO] index;
      logic [`EXU_BTAG_SIZE-1:0]               btag;
   } predpipe_t;

   // Data enables pulse one cycle, control enables two
   typedef struct packed {
      logic data_x;
      logic data_r;
      logic ctl_x;
      logic ctl_r;
   } stage_en_t;

   typedef struct packed {
      logic [`EXU_XLEN-1:0] result_r;  // Enable bit 0
      logic [`EXU_XLEN-1:0] load_m;    // Enable bit 1
      logic [`EXU_XLEN-1:0] result_x;  // Enable bit 2
      logic [`EXU_XLEN-1:0] load_nb;   // Enable bit 3
   } bypass_t;

   typedef struct packed {
      logic                 flush_upper;
      logic [`EXU_XLEN-1:1] flush_path;
      logic                 pred_correct;
   } resolve_t;

   typedef struct packed {
      logic                                    valid;
      logic                                    misp;
      logic                                    way;
      logic [1:0]                              hist;
      logic                                    error;
      logic                                    start_error;
      logic                                    middle;
      logic [`EXU_BTB_ADDR_HI:`EXU_BTB_ADDR_LO] index;
      logic [`EXU_GHR_SIZE-1:0]                fghr;
   } br_update_t;

   typedef struct packed {
      predict_pkt_t                            pkt;
      logic [`EXU_BTB_ADDR_HI:`EXU_BTB_ADDR_LO] index;
      logic [`EXU_BTAG_SIZE-1:0]               btag;
      logic [`EXU_GHR_SIZE-1:0]                eghr;   // History for the BHT write
   } mispredict_t;

endpackage

// File: hdl/exu_top.sv
// Execute unit forwarding slice, top level
// Operand selection, branch prediction pipe and global history
// tracking. The history tracker supplies the mispredict history
// that completes the branch pipe's mispredict report.

`timescale 1ns/1ps

`include "exu_params.svh"

module exu_top (
   input  logic                         clk,
   input  logic                         i_rst_n,
   input  exu_pkg::stage_en_t           i_en,
   input  exu_pkg::bypass_t             i_byp,
   input  logic [`EXU_BYP_SRCS-1:0]     i_rs1_byp_en,
   input  logic [`EXU_BYP_SRCS-1:0]     i_rs2_byp_en,
   input  logic                         i_rs1_en,
   input  logic                         i_rs2_en,
   input  logic                         i_select_pc,
   input  logic                         i_dbg_rs1,
   input  logic                         i_qual_lsu,
   input  logic                         i_extint_stall,
   input  logic [`EXU_XLEN-1:0]         i_gpr_rs1,
   input  logic [`EXU_XLEN-1:0]         i_gpr_rs2,
   input  logic [`EXU_XLEN-1:0]         i_immed,
   input  logic [`EXU_XLEN-1:0]         i_dbg_wrdata,
   input  logic [`EXU_XLEN-1:1]         i_pc_d,             // D-stage instruction PC
   input  logic [`EXU_XLEN-1:2]         i_meihap,
   input  exu_pkg::predict_pkt_t        i_pp_d,
   input  exu_pkg::predpipe_t           i_predpipe_d,
   input  exu_pkg::resolve_t            i_res_d,
   input  logic [`EXU_XLEN-1:1]         i_npc_x,
   input  logic [`EXU_XLEN-1:1]         i_flush_path_lower,
   input  logic                         i_branch_d,
   input  logic                         i_alu_decode_d,
   input  logic                         i_flush_lower,
   output logic [`EXU_XLEN-1:0]         o_rs1,
   output logic [`EXU_XLEN-1:0]         o_rs2,
   output logic [`EXU_XLEN-1:0]         o_lsu_rs1,
   output logic [`EXU_XLEN-1:0]         o_lsu_rs2,
   output exu_pkg::br_update_t          o_br_update,
   output exu_pkg::mispredict_t         o_mp,
   output logic                         o_flush_final,
   output logic [`EXU_XLEN-1:1]         o_flush_path_final,
   output logic [`EXU_XLEN-1:1]         o_npc_r
);
   import exu_pkg::*;

   mispredict_t              mp_bp;             // eghr not yet filled
   logic [`EXU_GHR_SIZE-1:0] eghr;
   logic                     valid_d;
   logic                     taken_d;
   logic                     flush_upper_x;

   operand_select u_operand_select (
      .i_byp          (i_byp),
      .i_rs1_byp_en   (i_rs1_byp_en),
      .i_rs2_byp_en   (i_rs2_byp_en),
      .i_rs1_en       (i_rs1_en),
      .i_rs2_en       (i_rs2_en),
      .i_select_pc    (i_select_pc),
      .i_dbg_rs1      (i_dbg_rs1),
      .i_qual_lsu     (i_qual_lsu),
      .i_extint_stall (i_extint_stall),
      .i_gpr_rs1      (i_gpr_rs1),
      .i_gpr_rs2      (i_gpr_rs2),
      .i_immed        (i_immed),
      .i_dbg_wrdata   (i_dbg_wrdata),
      .i_pc           (i_pc_d),
      .i_meihap       (i_meihap),
      .o_rs1          (o_rs1),
      .o_rs2          (o_rs2),
      .o_lsu_rs1      (o_lsu_rs1),
      .o_lsu_rs2      (o_lsu_rs2)
   );

   branch_pipe u_branch_pipe (
      .clk                (clk),
      .i_rst_n            (i_rst_n),
      .i_en               (i_en),
      .i_pp_d             (i_pp_d),
      .i_predpipe_d       (i_predpipe_d),
      .i_res_d            (i_res_d),
      .i_pc_d             (i_pc_d),
      .i_npc_x            (i_npc_x),
      .i_flush_path_lower (i_flush_path_lower),
      .i_branch_d         (i_branch_d),
      .i_alu_decode_d     (i_alu_decode_d),
      .i_flush_lower      (i_flush_lower),
      .o_br_update        (o_br_update),
      .o_mp               (mp_bp),
      .o_flush_final      (o_flush_final),
      .o_flush_path_final (o_flush_path_final),
      .o_npc_r            (o_npc_r),
      .o_valid_d          (valid_d),
      .o_taken_d          (taken_d),
      .o_flush_upper_x    (flush_upper_x)
   );

   ghr_tracker u_ghr_tracker (
      .clk             (clk),
      .i_rst_n         (i_rst_n),
      .i_ctl_x         (i_en.ctl_x),
      .i_valid_d       (valid_d),
      .i_taken_d       (taken_d),
      .i_flush_upper_x (flush_upper_x),
      .i_flush_lower   (i_flush_lower),
      .o_eghr          (eghr)
   );

   always_comb begin
      o_mp      = mp_bp;
      o_mp.eghr = eghr;
   end

endmodule

// File: hdl/ghr_tracker.sv
// Global history tracker
// Speculative history at D, history in commit order at X.
// A lower flush restores D from X; the mispredict history is
// taken from D when only X flushes upper.

`timescale 1ns/1ps

`include "exu_params.svh"

module ghr_tracker (
   input  logic                      clk,
   input  logic                      i_rst_n,
   input  logic                      i_ctl_x,          // X control enable
   input  logic                      i_valid_d,
   input  logic                      i_taken_d,
   input  logic                      i_flush_upper_x,
   input  logic                      i_flush_lower,
   output logic [`EXU_GHR_SIZE-1:0]  o_eghr
);

   logic [`EXU_GHR_SIZE-1:0] ghr_d;
   logic [`EXU_GHR_SIZE-1:0] ghr_d_ns;
   logic [`EXU_GHR_SIZE-1:0] ghr_x;
   logic [`EXU_GHR_SIZE-1:0] ghr_x_ns;
   logic                     valid_x;
   logic                     taken_x;

   always_comb begin
      if (i_flush_lower)
         ghr_d_ns = ghr_x;                                  // Restore after flush
      else if (i_valid_d)
         ghr_d_ns = {ghr_d[`EXU_GHR_SIZE-2:0], i_taken_d};
      else
         ghr_d_ns = ghr_d;
   end

   assign ghr_x_ns = valid_x ? {ghr_x[`EXU_GHR_SIZE-2:0], taken_x} : ghr_x;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n)
         ghr_d <= '0;
      else
         ghr_d <= ghr_d_ns;                                 // Loads every clock
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         valid_x <= 1'b0;
         taken_x <= 1'b0;
         ghr_x   <= '0;
      end else if (i_ctl_x) begin
         valid_x <= i_valid_d;
         taken_x <= i_taken_d;
         ghr_x   <= ghr_x_ns;
      end
   end

   assign o_eghr = (i_flush_upper_x & ~i_flush_lower) ? ghr_d : ghr_x;

endmodule

// File: hdl/operand_select.sv
// Operand select
// Merges the four bypass sources per operand and picks rs1/rs2 from
// bypass, PC, debug data, register file or immediate. Also drives the
// gated load/store operands, with the interrupt vector address
// replacing rs1 during an external interrupt stall.

`timescale 1ns/1ps

`include "exu_params.svh"

module operand_select (
   input  exu_pkg::bypass_t               i_byp,
   input  logic [`EXU_BYP_SRCS-1:0]       i_rs1_byp_en,    // One-hot per source
   input  logic [`EXU_BYP_SRCS-1:0]       i_rs2_byp_en,
   input  logic                           i_rs1_en,        // GPR rs1 qualifier
   input  logic                           i_rs2_en,
   input  logic                           i_select_pc,     // jal/auipc use PC
   input  logic                           i_dbg_rs1,
   input  logic                           i_qual_lsu,
   input  logic                           i_extint_stall,
   input  logic [`EXU_XLEN-1:0]           i_gpr_rs1,
   input  logic [`EXU_XLEN-1:0]           i_gpr_rs2,
   input  logic [`EXU_XLEN-1:0]           i_immed,
   input  logic [`EXU_XLEN-1:0]           i_dbg_wrdata,
   input  logic [`EXU_XLEN-1:1]           i_pc,
   input  logic [`EXU_XLEN-1:2]           i_meihap,        // Interrupt handler address
   output logic [`EXU_XLEN-1:0]           o_rs1,
   output logic [`EXU_XLEN-1:0]           o_rs2,
   output logic [`EXU_XLEN-1:0]           o_lsu_rs1,
   output logic [`EXU_XLEN-1:0]           o_lsu_rs2
);
   import exu_pkg::*;

   logic [`EXU_XLEN-1:0] rs1_byp_data;
   logic [`EXU_XLEN-1:0] rs2_byp_data;
   logic [`EXU_XLEN-1:0] gpr_rs1_q;
   logic [`EXU_XLEN-1:0] gpr_rs2_q;
   logic                 rs1_byp;
   logic                 rs2_byp;

   // AND-OR merge, more than one enable ORs the sources
   function automatic logic [`EXU_XLEN-1:0] byp_merge(input bypass_t                  byp,
                                                      input logic [`EXU_BYP_SRCS-1:0] en);
      return ({`EXU_XLEN{en[0]}} & byp.result_r) |
             ({`EXU_XLEN{en[1]}} & byp.load_m)   |
             ({`EXU_XLEN{en[2]}} & byp.result_x) |
             ({`EXU_XLEN{en[3]}} & byp.load_nb);
   endfunction

   assign rs1_byp      = |i_rs1_byp_en;
   assign rs2_byp      = |i_rs2_byp_en;
   assign rs1_byp_data = byp_merge(i_byp, i_rs1_byp_en);
   assign rs2_byp_data = byp_merge(i_byp, i_rs2_byp_en);
   assign gpr_rs1_q    = {`EXU_XLEN{i_rs1_en}} & i_gpr_rs1;
   assign gpr_rs2_q    = {`EXU_XLEN{i_rs2_en}} & i_gpr_rs2;

   always_comb begin
      if (rs1_byp)
         o_rs1 = rs1_byp_data;
      else if (i_select_pc)
         o_rs1 = {i_pc, 1'b0};
      else if (i_dbg_rs1)
         o_rs1 = i_dbg_wrdata;                  // Debug register write
      else
         o_rs1 = gpr_rs1_q;
   end

   assign o_rs2 = rs2_byp ? rs2_byp_data : (gpr_rs2_q | i_immed);

   // Quiet operands keep the LSU address path from toggling
   always_comb begin
      o_lsu_rs1 = '0;
      o_lsu_rs2 = '0;
      if (i_qual_lsu) begin
         if (i_extint_stall) begin
            o_lsu_rs1 = {i_meihap, 2'b00};      // Vector table fetch
         end else begin
            o_lsu_rs1 = rs1_byp ? rs1_byp_data : gpr_rs1_q;
            o_lsu_rs2 = rs2_byp ? rs2_byp_data : gpr_rs2_q;
         end
      end
   end

endmodule

// File: include/exu_params.svh
// Execute unit forwarding slice parameters
// Widths for data, branch history, BTB index, branch tag
// and the number of operand bypass sources

`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

// Data path width
`define EXU_XLEN 32

// Global branch history length
`define EXU_GHR_SIZE 8

// BTB index bounds, 8-bit index
`define EXU_BTB_ADDR_HI 9
`define EXU_BTB_ADDR_LO 2

// Branch tag width
`define EXU_BTAG_SIZE 5

// Bypass sources per operand
`define EXU_BYP_SRCS 4

`endif
